/* project.f */
source/axi_w_pkg.sv
source/tlb_pkg.sv
source/w_stream_fifo.sv
source/w_input_stage.sv
source/w_burst_ctrl.sv
source/w_drop_gate.sv
tests/tb_w_drop_gate.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it from the project root and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_w_drop_gate -f project.f -o tb_w_drop_gate \
  && ./obj_dir/tb_w_drop_gate > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

/* source/axi_w_pkg.sv */
// W-channel widths and beat layout; strobe width is fixed at one bit per data byte
`default_nettype none

package axi_w_pkg;

  // Data bus width in bits as a whole number of bytes
  localparam int unsigned DATA_WIDTH = 32;

  // Width of the user sideband carried with every beat
  localparam int unsigned USER_WIDTH = 4;

  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [USER_WIDTH-1:0]   user_t;

  // One W beat as it sits in the input buffer
  typedef struct packed {
    data_t data;
    strb_t strb;
    user_t user;
    logic  last;
  } w_beat_t;

endpackage : axi_w_pkg

`default_nettype wire

/* source/tlb_pkg.sv */
// Translation decision types; every descriptor is either accept or drop, never both
`default_nettype none

package tlb_pkg;

  // AXI id width shared by the AW and B sides
  localparam int unsigned ID_WIDTH = 4;

  typedef logic [ID_WIDTH-1:0] id_t;

  // AXI burst length minus one
  typedef logic [7:0] burst_len_t;

  // One per-burst decision from the L1 translation stage
  typedef struct packed {
    logic       prefetch;
    logic       hit;
    id_t        id;
    burst_len_t len;
    logic       master;
    logic       accept;
    logic       drop;
  } tlb_desc_t;

  // Burst controller states
  typedef enum logic [1:0] {
    WAIT_DESC,
    FORWARD,
    DISCARD,
    DROP_WAIT
  } burst_state_t;

endpackage : tlb_pkg

`default_nettype wire

/* source/w_burst_ctrl.sv */
// Handles one burst at a time in descriptor order; beats must arrive in the same order
`default_nettype none

module w_burst_ctrl (
  input  wire logic                  axi4_aclk,
  input  wire logic                  axi4_arstn,
  // Buffered beats and descriptors
  input  wire axi_w_pkg::w_beat_t    beat_i,
  input  wire logic                  beat_valid_i,
  output logic                       beat_ready_o,
  input  wire tlb_pkg::tlb_desc_t    desc_i,
  input  wire logic                  desc_valid_i,
  output logic                       desc_pop_o,
  // Downstream W channel
  output axi_w_pkg::data_t           m_wdata_o,
  output axi_w_pkg::strb_t           m_wstrb_o,
  output axi_w_pkg::user_t           m_wuser_o,
  output logic                       m_wlast_o,
  output logic                       m_wvalid_o,
  input  wire logic                  m_wready_i,
  output logic                       master_select_o,
  // B sender handshake
  output logic                       b_drop_o,
  input  wire logic                  b_done_i,
  output tlb_pkg::id_t               id_o,
  output logic                       prefetch_o,
  output logic                       hit_o
);

  import tlb_pkg::*;

  burst_state_t state_q;
  burst_state_t state_d;
  logic         beat_xfer;

  assign beat_xfer = beat_valid_i & beat_ready_o;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      state_q <= WAIT_DESC;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    beat_ready_o = 1'b0;
    desc_pop_o   = 1'b0;
    // Downstream fields stay zero unless a burst is being forwarded
    m_wdata_o    = '0;
    m_wstrb_o    = '0;
    m_wuser_o    = '0;
    m_wlast_o    = 1'b0;
    m_wvalid_o   = 1'b0;

    case (state_q)
      WAIT_DESC: begin
        if (desc_valid_i) begin
          if (desc_i.accept) begin
            state_d = FORWARD;
          end else if (desc_i.drop) begin
            state_d = DISCARD;
          end
        end
      end

      FORWARD: begin
        m_wdata_o    = beat_i.data;
        m_wstrb_o    = beat_i.strb;
        m_wuser_o    = beat_i.user;
        m_wlast_o    = beat_i.last;
        m_wvalid_o   = beat_valid_i;
        beat_ready_o = m_wready_i;
        // Burst done on the last handshake
        if (beat_xfer && beat_i.last) begin
          desc_pop_o = 1'b1;
          state_d    = WAIT_DESC;
        end
      end

      DISCARD: begin
        // Sink every beat of the burst
        beat_ready_o = 1'b1;
        if (beat_xfer && beat_i.last) begin
          state_d = DROP_WAIT;
        end
      end

      DROP_WAIT: begin
        if (b_done_i) begin
          desc_pop_o = 1'b1;
          state_d    = WAIT_DESC;
        end
      end

      default: begin
        state_d = WAIT_DESC;
      end
    endcase
  end

  // Head descriptor stays put until popped, so these hold through DROP_WAIT
  assign b_drop_o        = (state_q == DROP_WAIT);
  assign id_o            = desc_i.id;
  assign prefetch_o      = desc_i.prefetch;
  assign hit_o           = desc_i.hit;
  assign master_select_o = desc_i.master;

  a_drop_held: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    (b_drop_o && !b_done_i) |=> b_drop_o
  );

  a_drop_id_stable: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    (b_drop_o && !b_done_i) |=> $stable(id_o)
  );

  // The queue in the input stage must never be popped while empty
  a_pop_valid: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    desc_pop_o |-> desc_valid_i
  );

endmodule : w_burst_ctrl

`default_nettype wire

/* source/w_drop_gate.sv */
// W gate behind L1 translation only; one burst in flight, drops wait for b_done_i
`default_nettype none

module w_drop_gate #(
  parameter int unsigned W_FIFO_DEPTH    = 4,
  parameter int unsigned DESC_FIFO_DEPTH = 8
) (
  input  wire logic                  axi4_aclk,
  input  wire logic                  axi4_arstn,
  // Upstream W
  input  wire axi_w_pkg::data_t      s_wdata_i,
  input  wire axi_w_pkg::strb_t      s_wstrb_i,
  input  wire axi_w_pkg::user_t      s_wuser_i,
  input  wire logic                  s_wlast_i,
  input  wire logic                  s_wvalid_i,
  output logic                       s_wready_o,
  // Downstream W
  output axi_w_pkg::data_t           m_wdata_o,
  output axi_w_pkg::strb_t           m_wstrb_o,
  output axi_w_pkg::user_t           m_wuser_o,
  output logic                       m_wlast_o,
  output logic                       m_wvalid_o,
  input  wire logic                  m_wready_i,
  // L1 decision
  input  wire logic                  l1_accept_i,
  input  wire logic                  l1_drop_i,
  input  wire logic                  l1_master_i,
  input  wire tlb_pkg::id_t          l1_id_i,
  input  wire tlb_pkg::burst_len_t   l1_len_i,
  input  wire logic                  l1_prefetch_i,
  input  wire logic                  l1_hit_i,
  output logic                       l1_done_o,
  output logic                       input_stall_o,
  // B sender
  output logic                       b_drop_o,
  output tlb_pkg::id_t               id_o,
  output logic                       prefetch_o,
  output logic                       hit_o,
  input  wire logic                  b_done_i,
  // Routing
  output logic                       master_select_o
);

  import axi_w_pkg::*;
  import tlb_pkg::*;

  w_beat_t   beat;
  logic      beat_valid;
  logic      beat_ready;
  tlb_desc_t desc;
  logic      desc_valid;
  logic      desc_pop;

  w_input_stage #(
    .W_FIFO_DEPTH    (W_FIFO_DEPTH),
    .DESC_FIFO_DEPTH (DESC_FIFO_DEPTH)
  ) u_w_input_stage (
    .axi4_aclk     (axi4_aclk),
    .axi4_arstn    (axi4_arstn),
    .s_wdata_i     (s_wdata_i),
    .s_wstrb_i     (s_wstrb_i),
    .s_wuser_i     (s_wuser_i),
    .s_wlast_i     (s_wlast_i),
    .s_wvalid_i    (s_wvalid_i),
    .s_wready_o    (s_wready_o),
    .l1_accept_i   (l1_accept_i),
    .l1_drop_i     (l1_drop_i),
    .l1_master_i   (l1_master_i),
    .l1_prefetch_i (l1_prefetch_i),
    .l1_hit_i      (l1_hit_i),
    .l1_id_i       (l1_id_i),
    .l1_len_i      (l1_len_i),
    .l1_done_o     (l1_done_o),
    .input_stall_o (input_stall_o),
    .beat_o        (beat),
    .beat_valid_o  (beat_valid),
    .beat_ready_i  (beat_ready),
    .desc_o        (desc),
    .desc_valid_o  (desc_valid),
    .desc_pop_i    (desc_pop)
  );

  w_burst_ctrl u_w_burst_ctrl (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .beat_i          (beat),
    .beat_valid_i    (beat_valid),
    .beat_ready_o    (beat_ready),
    .desc_i          (desc),
    .desc_valid_i    (desc_valid),
    .desc_pop_o      (desc_pop),
    .m_wdata_o       (m_wdata_o),
    .m_wstrb_o       (m_wstrb_o),
    .m_wuser_o       (m_wuser_o),
    .m_wlast_o       (m_wlast_o),
    .m_wvalid_o      (m_wvalid_o),
    .m_wready_i      (m_wready_i),
    .master_select_o (master_select_o),
    .b_drop_o        (b_drop_o),
    .b_done_i        (b_done_i),
    .id_o            (id_o),
    .prefetch_o      (prefetch_o),
    .hit_o           (hit_o)
  );

endmodule : w_drop_gate

`default_nettype wire

/* source/w_input_stage.sv */
// Input buffers; the L1 stage must never raise accept and drop in the same cycle
`default_nettype none

module w_input_stage #(
  parameter int unsigned W_FIFO_DEPTH    = 4,
  parameter int unsigned DESC_FIFO_DEPTH = 8
) (
  input  wire logic                  axi4_aclk,
  input  wire logic                  axi4_arstn,
  // Upstream W channel
  input  wire axi_w_pkg::data_t      s_wdata_i,
  input  wire axi_w_pkg::strb_t      s_wstrb_i,
  input  wire axi_w_pkg::user_t      s_wuser_i,
  input  wire logic                  s_wlast_i,
  input  wire logic                  s_wvalid_i,
  output logic                       s_wready_o,
  // L1 decision strobe
  input  wire logic                  l1_accept_i,
  input  wire logic                  l1_drop_i,
  input  wire logic                  l1_master_i,
  input  wire logic                  l1_prefetch_i,
  input  wire logic                  l1_hit_i,
  input  wire tlb_pkg::id_t          l1_id_i,
  input  wire tlb_pkg::burst_len_t   l1_len_i,
  output logic                       l1_done_o,
  output logic                       input_stall_o,
  // Towards the burst controller
  output axi_w_pkg::w_beat_t         beat_o,
  output logic                       beat_valid_o,
  input  wire logic                  beat_ready_i,
  output tlb_pkg::tlb_desc_t         desc_o,
  output logic                       desc_valid_o,
  input  wire logic                  desc_pop_i
);

  import axi_w_pkg::*;
  import tlb_pkg::*;

  w_beat_t   beat_in;
  tlb_desc_t desc_in;
  logic      l1_req;
  logic      desc_ready;

  assign beat_in = '{data: s_wdata_i, strb: s_wstrb_i, user: s_wuser_i, last: s_wlast_i};

  assign desc_in = '{
    prefetch: l1_prefetch_i,
    hit:      l1_hit_i,
    id:       l1_id_i,
    len:      l1_len_i,
    master:   l1_master_i,
    accept:   l1_accept_i,
    drop:     l1_drop_i
  };

  w_stream_fifo #(
    .WIDTH ($bits(w_beat_t)),
    .DEPTH (W_FIFO_DEPTH)
  ) u_w_fifo (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (beat_in),
    .valid_i    (s_wvalid_i),
    .ready_o    (s_wready_o),
    .data_o     (beat_o),
    .valid_o    (beat_valid_o),
    .ready_i    (beat_ready_i)
  );

  // Any decision is a request; it is taken whenever the queue has room
  assign l1_req        = l1_accept_i | l1_drop_i;
  assign l1_done_o     = l1_req & desc_ready;
  assign input_stall_o = ~desc_ready;

  w_stream_fifo #(
    .WIDTH ($bits(tlb_desc_t)),
    .DEPTH (DESC_FIFO_DEPTH)
  ) u_desc_fifo (
    .axi4_aclk  (axi4_aclk),
    .axi4_arstn (axi4_arstn),
    .data_i     (desc_in),
    .valid_i    (l1_req),
    .ready_o    (desc_ready),
    .data_o     (desc_o),
    .valid_o    (desc_valid_o),
    .ready_i    (desc_pop_i)
  );

  a_one_decision: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    !(l1_accept_i && l1_drop_i)
  );

endmodule : w_input_stage

`default_nettype wire

/* source/w_stream_fifo.sv */
// Circular FIFO where a push shows at the output one cycle later with no fall-through; DEPTH >= 1
`default_nettype none

module w_stream_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 4
) (
  input  wire logic             axi4_aclk,
  input  wire logic             axi4_arstn,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  output logic      [WIDTH-1:0] data_o,
  output logic                  valid_o,
  input  wire logic             ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Entry storage
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves occupancy unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Occupancy never runs past the storage
  a_no_overflow: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    count_q <= CNT_W'(DEPTH)
  );

  // An empty FIFO has both pointers on the same slot
  a_no_underflow: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    (count_q == '0) |-> (wr_ptr_q == rd_ptr_q)
  );

  // A push into an empty FIFO appears at the output on the next cycle
  a_push_latency: assert property (
    @(posedge axi4_aclk) disable iff (!axi4_arstn)
    (push && count_q == '0) |=> (valid_o && data_o == $past(data_i))
  );

endmodule : w_stream_fifo

`default_nettype wire

/* tests/tb_w_drop_gate.sv */
// Run from the project root; the data file must hold between nine and 32 bursts
`default_nettype none

module tb_w_drop_gate;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_w_pkg::*;
  import tlb_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int TIMEOUT    = 2000;
  localparam int MAX_BURSTS = 32;
  localparam int W_DEPTH    = 4;
  localparam int DESC_DEPTH = 8;

  logic       axi4_aclk;
  logic       axi4_arstn;
  data_t      s_wdata_i;
  strb_t      s_wstrb_i;
  user_t      s_wuser_i;
  logic       s_wlast_i;
  logic       s_wvalid_i;
  logic       s_wready_o;
  data_t      m_wdata_o;
  strb_t      m_wstrb_o;
  user_t      m_wuser_o;
  logic       m_wlast_o;
  logic       m_wvalid_o;
  logic       m_wready_i;
  logic       l1_accept_i;
  logic       l1_drop_i;
  logic       l1_master_i;
  id_t        l1_id_i;
  burst_len_t l1_len_i;
  logic       l1_prefetch_i;
  logic       l1_hit_i;
  logic       l1_done_o;
  logic       input_stall_o;
  logic       b_drop_o;
  id_t        id_o;
  logic       prefetch_o;
  logic       hit_o;
  logic       b_done_i;
  logic       master_select_o;

  // Burst table loaded from the data file
  logic       b_accept [MAX_BURSTS];
  id_t        b_id     [MAX_BURSTS];
  logic       b_master [MAX_BURSTS];
  logic       b_pref   [MAX_BURSTS];
  logic       b_hit    [MAX_BURSTS];
  burst_len_t b_len    [MAX_BURSTS];
  data_t      b_data   [MAX_BURSTS];
  int         n_bursts = 0;

  // Expected downstream beats and dropped bursts, in order
  data_t exp_data   [$];
  user_t exp_user   [$];
  logic  exp_last   [$];
  logic  exp_master [$];
  int    drop_q     [$];

  int errors       = 0;
  int checks       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  bit abort        = 1'b0;
  int seed         = 32'hca89_2444;

  w_drop_gate #(
    .W_FIFO_DEPTH    (W_DEPTH),
    .DESC_FIFO_DEPTH (DESC_DEPTH)
  ) u_w_drop_gate (
    .axi4_aclk       (axi4_aclk),
    .axi4_arstn      (axi4_arstn),
    .s_wdata_i       (s_wdata_i),
    .s_wstrb_i       (s_wstrb_i),
    .s_wuser_i       (s_wuser_i),
    .s_wlast_i       (s_wlast_i),
    .s_wvalid_i      (s_wvalid_i),
    .s_wready_o      (s_wready_o),
    .m_wdata_o       (m_wdata_o),
    .m_wstrb_o       (m_wstrb_o),
    .m_wuser_o       (m_wuser_o),
    .m_wlast_o       (m_wlast_o),
    .m_wvalid_o      (m_wvalid_o),
    .m_wready_i      (m_wready_i),
    .l1_accept_i     (l1_accept_i),
    .l1_drop_i       (l1_drop_i),
    .l1_master_i     (l1_master_i),
    .l1_id_i         (l1_id_i),
    .l1_len_i        (l1_len_i),
    .l1_prefetch_i   (l1_prefetch_i),
    .l1_hit_i        (l1_hit_i),
    .l1_done_o       (l1_done_o),
    .input_stall_o   (input_stall_o),
    .b_drop_o        (b_drop_o),
    .id_o            (id_o),
    .prefetch_o      (prefetch_o),
    .hit_o           (hit_o),
    .b_done_i        (b_done_i),
    .master_select_o (master_select_o)
  );

  initial begin
    axi4_aclk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) axi4_aclk = ~axi4_aclk;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic record_timeout(input string what);
    if (!abort) begin
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
    end
    errors++;
    abort = 1'b1;
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic read_tests();
    int               fd;
    int               n;
    logic [63:0]      tok;
    logic [8*160-1:0] rest;
    fd = $fopen("tests/w_drop_gate_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/w_drop_gate_tests.txt");
      errors++;
      abort = 1'b1;
    end else begin
      while (!$feof(fd) && n_bursts < MAX_BURSTS) begin
        tok = '0;
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          break;
        end
        if (tok == {56'h0, "#"}) begin
          n = $fgets(rest, fd);
        end else begin
          n = $fscanf(fd, "%h %h %h %h %h %h", b_id[n_bursts], b_master[n_bursts],
                      b_pref[n_bursts], b_hit[n_bursts], b_len[n_bursts], b_data[n_bursts]);
          if (n != 6 || (tok != {56'h0, "A"} && tok != {56'h0, "D"})) begin
            $display("Malformed burst line %0d in the data file", n_bursts);
            errors++;
            abort = 1'b1;
            break;
          end
          b_accept[n_bursts] = (tok == {56'h0, "A"});
          n_bursts++;
        end
      end
      $fclose(fd);
      if (!abort && n_bursts < DESC_DEPTH + 1) begin
        $display("Data file holds %0d bursts, at least %0d are needed", n_bursts,
                 DESC_DEPTH + 1);
        errors++;
        abort = 1'b1;
      end
    end
  endtask

  // Builds the expected beat stream where beat k carries data0 + k and user k mod 16
  task automatic load_expect(input int first, input int count);
    int i;
    int k;
    exp_data.delete();
    exp_user.delete();
    exp_last.delete();
    exp_master.delete();
    drop_q.delete();
    for (i = first; i < first + count; i++) begin
      if (b_accept[i]) begin
        for (k = 0; k <= int'(b_len[i]); k++) begin
          exp_data.push_back(b_data[i] + data_t'(k));
          exp_user.push_back(user_t'(k % 16));
          exp_last.push_back(k == int'(b_len[i]));
          exp_master.push_back(b_master[i]);
        end
      end else begin
        drop_q.push_back(i);
      end
    end
  endtask

  task automatic present_desc(input int i);
    @(posedge axi4_aclk);
    l1_accept_i   <= b_accept[i];
    l1_drop_i     <= ~b_accept[i];
    l1_id_i       <= b_id[i];
    l1_master_i   <= b_master[i];
    l1_prefetch_i <= b_pref[i];
    l1_hit_i      <= b_hit[i];
    l1_len_i      <= b_len[i];
  endtask

  task automatic wait_desc_done(input int i);
    int waited;
    waited = 0;
    @(negedge axi4_aclk);
    while (!l1_done_o && !abort && waited < TIMEOUT) begin
      @(negedge axi4_aclk);
      waited++;
    end
    if (!l1_done_o) begin
      record_timeout($sformatf("l1_done_o on descriptor %0d", i));
    end
    // The queue takes the descriptor on this edge
    @(posedge axi4_aclk);
    l1_accept_i <= 1'b0;
    l1_drop_i   <= 1'b0;
  endtask

  task automatic drive_beats(input int first, input int count);
    int i;
    int k;
    int waited;
    for (i = first; i < first + count && !abort; i++) begin
      for (k = 0; k <= int'(b_len[i]) && !abort; k++) begin
        @(posedge axi4_aclk);
        s_wvalid_i <= 1'b1;
        s_wdata_i  <= b_data[i] + data_t'(k);
        s_wstrb_i  <= '1;
        s_wuser_i  <= user_t'(k % 16);
        s_wlast_i  <= (k == int'(b_len[i]));
        waited = 0;
        @(negedge axi4_aclk);
        while (!s_wready_o && !abort && waited < TIMEOUT) begin
          @(negedge axi4_aclk);
          waited++;
        end
        if (!s_wready_o) begin
          record_timeout($sformatf("s_wready_o on burst %0d beat %0d", i, k));
        end
      end
    end
    @(posedge axi4_aclk);
    s_wvalid_i <= 1'b0;
    s_wlast_i  <= 1'b0;
  endtask

  task automatic answer_drops();
    int idx;
    int waited;
    int delay;
    int rnd;
    while (drop_q.size() > 0 && !abort) begin
      idx    = drop_q.pop_front();
      waited = 0;
      @(negedge axi4_aclk);
      while (!b_drop_o && !abort && waited < TIMEOUT) begin
        @(negedge axi4_aclk);
        waited++;
      end
      if (!b_drop_o) begin
        record_timeout($sformatf("b_drop_o on burst %0d", idx));
      end else begin
        check_value("id_o", 32'(id_o), 32'(b_id[idx]));
        check_value("prefetch_o", 32'(prefetch_o), 32'(b_pref[idx]));
        check_value("hit_o", 32'(hit_o), 32'(b_hit[idx]));
        rnd   = $random(seed);
        delay = int'(rnd[2:0]);
        // Level must hold with the same id until the sender answers
        repeat (delay) begin
          @(negedge axi4_aclk);
          check_value("b_drop_o before b_done_i", 32'(b_drop_o), 32'd1);
          check_value("id_o while b_drop_o", 32'(id_o), 32'(b_id[idx]));
          check_value("m_wvalid_o during drop", 32'(m_wvalid_o), 32'd0);
        end
        @(posedge axi4_aclk);
        b_done_i <= 1'b1;
        @(posedge axi4_aclk);
        b_done_i <= 1'b0;
        @(negedge axi4_aclk);
        check_value("b_drop_o after b_done_i", 32'(b_drop_o), 32'd0);
      end
    end
  endtask

  task automatic watch_downstream(input bit random_ready);
    int    idle;
    int    rnd;
    data_t want_data;
    user_t want_user;
    logic  want_last;
    logic  want_master;
    idle = 0;
    while (exp_data.size() > 0 && !abort) begin
      @(posedge axi4_aclk);
      rnd = $random(seed);
      m_wready_i <= random_ready ? rnd[0] : 1'b1;
      @(negedge axi4_aclk);
      if (m_wvalid_o && m_wready_i) begin
        want_data   = exp_data.pop_front();
        want_user   = exp_user.pop_front();
        want_last   = exp_last.pop_front();
        want_master = exp_master.pop_front();
        check_value("m_wdata_o", m_wdata_o, want_data);
        check_value("m_wstrb_o", 32'(m_wstrb_o), 32'(strb_t'('1)));
        check_value("m_wuser_o", 32'(m_wuser_o), 32'(want_user));
        check_value("m_wlast_o", 32'(m_wlast_o), 32'(want_last));
        check_value("master_select_o", 32'(master_select_o), 32'(want_master));
        idle = 0;
      end else if (idle == TIMEOUT) begin
        record_timeout("a downstream beat");
      end else begin
        idle++;
      end
    end
    @(posedge axi4_aclk);
    m_wready_i <= 1'b1;
  endtask

  // Nothing may be left on the downstream side once every burst is done
  task automatic check_idle();
    @(negedge axi4_aclk);
    if (!abort) begin
      check_value("m_wvalid_o after the last burst", 32'(m_wvalid_o), 32'd0);
      check_value("b_drop_o after the last burst", 32'(b_drop_o), 32'd0);
    end
  endtask

  task automatic run_bursts(input int first, input int count, input bit random_ready);
    int i;
    load_expect(first, count);
    fork
      begin
        for (i = first; i < first + count && !abort; i++) begin
          present_desc(i);
          wait_desc_done(i);
        end
      end
      drive_beats(first, count);
      answer_drops();
      watch_downstream(random_ready);
    join
    check_idle();
  endtask

  task automatic fill_desc_queue();
    int i;
    load_expect(0, DESC_DEPTH + 1);
    // No W beats yet, so nothing leaves the queue
    for (i = 0; i < DESC_DEPTH && !abort; i++) begin
      present_desc(i);
      wait_desc_done(i);
    end
    present_desc(DESC_DEPTH);
    repeat (5) begin
      @(negedge axi4_aclk);
      check_value("input_stall_o with a full queue", 32'(input_stall_o), 32'd1);
      check_value("l1_done_o with a full queue", 32'(l1_done_o), 32'd0);
    end
    fork
      wait_desc_done(DESC_DEPTH);
      drive_beats(0, DESC_DEPTH + 1);
      answer_drops();
      watch_downstream(1'b1);
    join
    check_idle();
  endtask

  initial begin
    int errors_before;
    axi4_arstn    <= 1'b0;
    s_wdata_i     <= '0;
    s_wstrb_i     <= '0;
    s_wuser_i     <= '0;
    s_wlast_i     <= 1'b0;
    s_wvalid_i    <= 1'b0;
    m_wready_i    <= 1'b1;
    l1_accept_i   <= 1'b0;
    l1_drop_i     <= 1'b0;
    l1_master_i   <= 1'b0;
    l1_id_i       <= '0;
    l1_len_i      <= '0;
    l1_prefetch_i <= 1'b0;
    l1_hit_i      <= 1'b0;
    b_done_i      <= 1'b0;
    read_tests();
    repeat (2) @(posedge axi4_aclk);
    axi4_arstn <= 1'b1;

    errors_before = errors;
    @(negedge axi4_aclk);
    check_value("m_wvalid_o after reset", 32'(m_wvalid_o), 32'd0);
    check_value("b_drop_o after reset", 32'(b_drop_o), 32'd0);
    check_value("l1_done_o after reset", 32'(l1_done_o), 32'd0);
    check_value("input_stall_o after reset", 32'(input_stall_o), 32'd0);
    close_test("reset", errors_before);

    if (!abort) begin
      errors_before = errors;
      run_bursts(0, n_bursts, 1'b0);
      close_test("accept and drop", errors_before);
    end
    if (!abort) begin
      errors_before = errors;
      run_bursts(0, n_bursts, 1'b1);
      close_test("back-pressure", errors_before);
    end
    if (!abort) begin
      errors_before = errors;
      fill_desc_queue();
      close_test("full descriptor queue", errors_before);
    end

    $display("tests run %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_w_drop_gate

`default_nettype wire

/* tests/w_drop_gate_tests.txt */
# action (A accept, D drop), then id master prefetch hit len data0, all in hex
# len is the AXI burst length minus one, beat k carries data0 + k
A 1 0 0 1 03 10000000
D 2 1 1 0 02 20000000
A 3 1 0 1 00 30000000
A 4 0 1 1 07 40000000
D 5 0 0 0 00 50000000
A 6 1 1 0 05 60000000
D 7 1 0 1 04 70000000
A 8 0 0 1 01 80000000
A 9 1 1 1 06 90000000
D a 0 1 1 03 a0000000
A b 1 0 0 02 b0000000
A c 0 1 0 0f c0000000
D d 1 1 0 01 d0000000
D e 0 0 1 05 e0000000
A f 1 0 1 04 f0000000
A 0 0 1 1 00 0000fff0
D 1 1 1 1 07 11111111
A 2 0 0 0 03 22222222
A 3 1 0 0 09 33333333
D 4 0 1 0 02 44444444
A 5 1 1 1 01 55555555
A 6 0 0 1 0b 66666666
D 7 1 0 0 00 77777777
A 8 0 1 0 05 88888888
A 9 1 0 1 0f fffffffc
